//--- logic/cmd_engine.sv
`timescale 1ns/1ns

module cmd_engine (
	input  logic clock,
	input  logic reset,
	engine_ctrl_if.engine_side ctrl,
	output logic fifo_pop_o,
	input  logic [wb_host_pkg::DATA_W-1:0] fifo_data_i,
	input  logic fifo_empty_i
);
	import wb_host_pkg::*;

	op_e start_op;
	logic [7:0] start_count;
	op_e op;
	logic [7:0] remaining;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] acc_next;

	// Unknown opcodes fall back to clear
	always_comb begin
		case (ctrl.cmd.opcode)
			OP_SUM:  start_op = OP_SUM;
			OP_XOR:  start_op = OP_XOR;
			default: start_op = OP_CLEAR;
		endcase
	end

	// Clear never pops
	assign start_count = (start_op == OP_CLEAR) ? 8'd0 : ctrl.cmd.count;

	assign fifo_pop_o = ctrl.busy && (remaining != 8'd0) && !fifo_empty_i;

	always_comb begin
		case (op)
			OP_SUM:  acc_next = acc + fifo_data_i; // Wraps modulo 2^64
			OP_XOR:  acc_next = acc ^ fifo_data_i;
			default: acc_next = acc;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl.busy   <= 1'b0;
			ctrl.done   <= 1'b0;
			ctrl.result <= '0;
		end else if (ctrl.start) begin
			ctrl.busy <= 1'b1;
			ctrl.done <= 1'b0;
		end else if (ctrl.busy && remaining == 8'd0) begin
			ctrl.busy   <= 1'b0;
			ctrl.done   <= 1'b1;
			ctrl.result <= acc;
		end
	end

	// Operation state, only meaningful while busy
	always_ff @(posedge clock) begin
		if (ctrl.start) begin
			op        <= start_op;
			remaining <= start_count;
			acc       <= '0;
		end else if (fifo_pop_o) begin
			acc       <= acc_next;
			remaining <= remaining - 8'd1;
		end
	end

endmodule

//--- logic/data_fifo.sv
`timescale 1ns/1ns

module data_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic clock,
	input  logic reset,
	input  logic push_i,
	input  logic [wb_host_pkg::DATA_W-1:0] push_data_i,
	input  logic pop_i,
	output logic [wb_host_pkg::DATA_W-1:0] pop_data_o,
	input  logic flush_i,
	output logic full_o,
	output logic empty_o,
	output logic [$clog2(FIFO_DEPTH):0] level_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [wb_host_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full_o  = (level_o == FIFO_DEPTH);
	assign empty_o = (level_o == 0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign pop_data_o = mem[rd_ptr]; // Head word, valid while not empty

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clock) begin
		if (reset || flush_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
		end
	end

endmodule

//--- logic/engine_ctrl_if.sv
`timescale 1ns/1ns

interface engine_ctrl_if;
	import wb_host_pkg::*;

	logic start; // One cycle pulse
	cmd_t cmd;
	logic busy;
	logic done;  // Held until the next start
	logic [DATA_W-1:0] result;

	modport regs_side (
		output start,
		output cmd,
		input  busy,
		input  done,
		input  result
	);

	modport engine_side (
		input  start,
		input  cmd,
		output busy,
		output done,
		output result
	);

endinterface

//--- logic/host_link_if.sv
`timescale 1ns/1ns

// Four-phase handshake between the bus slave and the register block
interface host_link_if;
	import wb_host_pkg::*;

	logic req;
	logic we;
	wb_addr_e addr;
	logic [DATA_W-1:0] wdata;
	logic ack;
	logic [DATA_W-1:0] rdata; // Valid while ack is high

	modport slave_side (
		output req,
		output we,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport host_side (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

//--- logic/host_regs.sv
`timescale 1ns/1ns

module host_regs #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic clock,
	input  logic reset,
	host_link_if.host_side link,
	engine_ctrl_if.regs_side ctrl,
	output logic fifo_push_o,
	output logic [wb_host_pkg::DATA_W-1:0] fifo_data_o,
	output logic fifo_flush_o,
	input  logic fifo_full_i,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_level_i
);
	import wb_host_pkg::*;

	logic [DATA_W-1:0] status;
	logic [DATA_W-1:0] read_data;
	cmd_t new_cmd;
	logic is_clear;

	assign new_cmd = link.wdata;
	assign is_clear = !(new_cmd.opcode inside {OP_SUM, OP_XOR});

	always_comb begin
		status = '0;
		status[STAT_BUSY_BIT] = ctrl.busy;
		status[STAT_DONE_BIT] = ctrl.done;
		status[STAT_LEVEL_LSB +: STAT_LEVEL_W] = STAT_LEVEL_W'(fifo_level_i);
	end

	// Command and data addresses read back as zero
	always_comb begin
		case (link.addr)
			ADDR_RESULT: read_data = ctrl.result;
			ADDR_STATUS: read_data = status;
			default:     read_data = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			link.ack     <= 1'b0;
			ctrl.start   <= 1'b0;
			fifo_push_o  <= 1'b0;
			fifo_flush_o <= 1'b0;
		end else begin
			ctrl.start   <= 1'b0;
			fifo_push_o  <= 1'b0;
			fifo_flush_o <= 1'b0;
			if (link.ack) begin
				if (!link.req)
					link.ack <= 1'b0; // Last phase of the handshake
			end else if (link.req) begin
				if (!link.we) begin
					link.ack <= 1'b1;
				end else begin
					case (link.addr)
						ADDR_DATA: begin
							// Stall until the engine frees a slot
							if (!fifo_full_i) begin
								fifo_push_o <= 1'b1;
								link.ack    <= 1'b1;
							end
						end
						ADDR_CMD: begin
							if (!ctrl.busy) begin
								ctrl.start   <= 1'b1;
								fifo_flush_o <= is_clear;
								link.ack     <= 1'b1;
							end
						end
						default: link.ack <= 1'b1; // Read-only registers
					endcase
				end
			end
		end
	end

	// Payload registers
	always_ff @(posedge clock) begin
		if (link.req && !link.ack) begin
			link.rdata  <= link.we ? '0 : read_data;
			fifo_data_o <= link.wdata;
			if (link.we && link.addr == ADDR_CMD && !ctrl.busy)
				ctrl.cmd <= new_cmd;
		end
	end

endmodule

//--- logic/wb_host_pkg.sv
package wb_host_pkg;

	// Bus and accumulator width
	localparam int DATA_W = 64;

	// Register map seen by the Wishbone master
	typedef enum logic [1:0] {
		ADDR_CMD    = 2'd0, // Write only
		ADDR_DATA   = 2'd1, // Write only, pushes into the FIFO
		ADDR_RESULT = 2'd2, // Read only
		ADDR_STATUS = 2'd3  // Read only
	} wb_addr_e;

	// Engine opcodes, unknown codes behave like OP_CLEAR
	typedef enum logic [7:0] {
		OP_CLEAR = 8'h00,
		OP_SUM   = 8'h01,
		OP_XOR   = 8'h02
	} op_e;

	// Command word layout
	typedef struct packed {
		logic [7:0]  opcode;   // Bits 63..56
		logic [47:0] reserved; // Bits 55..8
		logic [7:0]  count;    // Words to pop
	} cmd_t;

	// Status word fields
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;
	localparam int STAT_LEVEL_LSB = 8;
	localparam int STAT_LEVEL_W   = 8;

endpackage

//--- logic/wb_host_top.sv
`timescale 1ns/1ns

module wb_host_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic clock,
	input  logic reset,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  wb_host_pkg::wb_addr_e adr_i,
	input  logic [wb_host_pkg::DATA_W-1:0] dat_i,
	output logic [wb_host_pkg::DATA_W-1:0] dat_o,
	output logic ack_o
);
	import wb_host_pkg::*;

	host_link_if link ();
	engine_ctrl_if ctrl ();

	// FIFO side wiring
	logic fifo_push;
	logic fifo_flush;
	logic fifo_pop;
	logic fifo_full;
	logic fifo_empty;
	logic [DATA_W-1:0] fifo_push_data;
	logic [DATA_W-1:0] fifo_pop_data;
	logic [$clog2(FIFO_DEPTH):0] fifo_level;

	wb_slave u_slave (
		.clock  (clock),
		.reset  (reset),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.dat_o  (dat_o),
		.ack_o  (ack_o),
		.link   (link.slave_side)
	);

	host_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
		.clock        (clock),
		.reset        (reset),
		.link         (link.host_side),
		.ctrl         (ctrl.regs_side),
		.fifo_push_o  (fifo_push),
		.fifo_data_o  (fifo_push_data),
		.fifo_flush_o (fifo_flush),
		.fifo_full_i  (fifo_full),
		.fifo_level_i (fifo_level)
	);

	data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clock       (clock),
		.reset       (reset),
		.push_i      (fifo_push),
		.push_data_i (fifo_push_data),
		.pop_i       (fifo_pop),
		.pop_data_o  (fifo_pop_data),
		.flush_i     (fifo_flush),
		.full_o      (fifo_full),
		.empty_o     (fifo_empty),
		.level_o     (fifo_level)
	);

	cmd_engine u_engine (
		.clock        (clock),
		.reset        (reset),
		.ctrl         (ctrl.engine_side),
		.fifo_pop_o   (fifo_pop),
		.fifo_data_i  (fifo_pop_data),
		.fifo_empty_i (fifo_empty)
	);

endmodule

//--- logic/wb_slave.sv
`timescale 1ns/1ns

module wb_slave (
	input  logic clock,
	input  logic reset,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  wb_host_pkg::wb_addr_e adr_i,
	input  logic [wb_host_pkg::DATA_W-1:0] dat_i,
	output logic [wb_host_pkg::DATA_W-1:0] dat_o,
	output logic ack_o,
	host_link_if.slave_side link
);
	import wb_host_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		ACK,
		RELEASE
	} state_e;

	state_e state;
	logic bus_active;

	assign bus_active = cyc_i && stb_i;

	// Address, direction and write data captured once per bus cycle
	always_ff @(posedge clock) begin
		if (state == IDLE && bus_active) begin
			link.we    <= we_i;
			link.addr  <= adr_i;
			link.wdata <= dat_i;
		end
	end

	// Read data follows the link and is sampled with the ack
	always_ff @(posedge clock) begin
		if (state == REQUEST && link.ack)
			dat_o <= link.rdata;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= IDLE;
			link.req <= 1'b0;
			ack_o    <= 1'b0;
		end else begin
			ack_o <= 1'b0; // Single cycle pulse by default
			case (state)
				IDLE: begin
					if (bus_active) begin
						link.req <= 1'b1;
						state    <= REQUEST;
					end
				end
				REQUEST: begin
					// Host side has acted, finish the bus cycle
					if (link.ack) begin
						link.req <= 1'b0;
						ack_o    <= bus_active; // Master may have abandoned the cycle
						state    <= ACK;
					end
				end
				ACK: begin
					state <= RELEASE;
				end
				RELEASE: begin
					// Both the link ack and the strobe must be gone
					if (!link.ack && !bus_active)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- test/wb_host_asserts.sv
`timescale 1ns/1ns

// Protocol checks on the Wishbone port and the internal req/ack link
module wb_host_asserts (
	input logic clock,
	input logic reset,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_o,
	input logic link_req,
	input logic link_ack,
	input logic busy
);

	int fail_count = 0; // Number of failed protocol checks

	ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		ack_o |-> (cyc_i && stb_i))
	else begin
		$error("ack_o raised outside an active bus cycle");
		fail_count++;
	end

	ack_single: assert property (@(posedge clock) disable iff (reset)
		ack_o |=> !ack_o)
	else begin
		$error("ack_o high for two consecutive cycles");
		fail_count++;
	end

	// Four-phase ordering
	link_ack_after_req: assert property (@(posedge clock) disable iff (reset)
		$rose(link_ack) |-> link_req)
	else begin
		$error("Link ack rose without a pending req");
		fail_count++;
	end

	link_req_after_ack: assert property (@(posedge clock) disable iff (reset)
		$rose(link_req) |-> !link_ack)
	else begin
		$error("Link req rose while ack was still high");
		fail_count++;
	end

	reset_state: assert property (@(posedge clock)
		$fell(reset) |-> (!busy && !ack_o))
	else begin
		$error("busy or ack_o not low after reset");
		fail_count++;
	end

endmodule

bind wb_host_top wb_host_asserts protocol_checks (
	.clock    (clock),
	.reset    (reset),
	.cyc_i    (cyc_i),
	.stb_i    (stb_i),
	.ack_o    (ack_o),
	.link_req (link.req),
	.link_ack (link.ack),
	.busy     (ctrl.busy)
);

//--- test/wb_host_tb.sv
`timescale 1ns/1ns

module wb_host_tb;
	import wb_host_pkg::*;

	localparam int TIMEOUT = 200;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic cyc_i = 1'b0;
	logic stb_i = 1'b0;
	logic we_i = 1'b0;
	wb_addr_e adr_i = ADDR_CMD;
	logic [63:0] dat_i = '0;
	logic [63:0] dat_o;
	logic ack_o;

	integer seed = 32'h9b8fccbf;
	logic [63:0] model_q [$]; // Words the FIFO should hold
	int latency;              // Cycles of the last write, stb to ack

	wb_host_top #(.FIFO_DEPTH(16)) dut (
		.clock (clock),
		.reset (reset),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.we_i  (we_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack_o (ack_o)
	);

	always #4 clock = ~clock;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Bus or link protocol violation seen by the bound checker
	always @(negedge clock) begin
		if (dut.protocol_checks.fail_count != 0)
			fail_run("Protocol assertion failed on the bus or link");
	end

	// One classic Wishbone cycle, held until ack_o
	task automatic bus_cycle(input logic we, input wb_addr_e addr, input logic [63:0] wdata,
			output logic [63:0] rdata, output int cycles);
		@(posedge clock);
		#1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = addr;
		dat_i = wdata;
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > TIMEOUT)
				fail_run($sformatf("Timeout: no ack_o for bus cycle at %s", addr.name()));
		end while (!ack_o);
		rdata = dat_o;
		@(posedge clock); // Slave samples the ack at this edge
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic write_reg(input wb_addr_e addr, input logic [63:0] data);
		logic [63:0] unused;
		bus_cycle(1'b1, addr, data, unused, latency);
	endtask

	task automatic check_read(input string name, input wb_addr_e addr, input logic [63:0] expected);
		logic [63:0] actual;
		int cycles;
		bus_cycle(1'b0, addr, '0, actual, cycles);
		assert (actual === expected)
		else fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
	endtask

	function automatic logic [63:0] status_word(input logic busy, input logic done, input int level);
		return {48'd0, 8'(level), 6'd0, done, busy};
	endfunction

	function automatic logic [63:0] command_word(input op_e op, input int count);
		return {8'(op), 48'd0, 8'(count)};
	endfunction

	task automatic push_words(input int count);
		logic [63:0] word;
		for (int i = 0; i < count; i++) begin
			word = {$random(seed), $random(seed)};
			model_q.push_back(word);
			write_reg(ADDR_DATA, word);
		end
	endtask

	// Reference reduction over the oldest words
	function automatic logic [63:0] model_reduce(input op_e op, input int count);
		logic [63:0] acc;
		acc = '0;
		for (int i = 0; i < count; i++) begin
			if (op == OP_SUM)
				acc = acc + model_q.pop_front();
			else
				acc = acc ^ model_q.pop_front();
		end
		return acc;
	endfunction

	task automatic wait_done();
		logic [63:0] status;
		int cycles;
		int polls;
		polls = 0;
		do begin
			bus_cycle(1'b0, ADDR_STATUS, '0, status, cycles);
			polls++;
			if (polls > TIMEOUT)
				fail_run("Timeout: done bit never set in status");
		end while (!status[1]);
	endtask

	initial begin
		logic [63:0] expected;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		check_read("reset_status", ADDR_STATUS, status_word(0, 0, 0));

		push_words(10);
		check_read("level_after_writes", ADDR_STATUS, status_word(0, 0, 10));

		expected = model_reduce(OP_SUM, 10);
		write_reg(ADDR_CMD, command_word(OP_SUM, 10));
		wait_done();
		check_read("sum_status", ADDR_STATUS, status_word(0, 1, 0));
		check_read("sum_result", ADDR_RESULT, expected);

		push_words(7);
		expected = model_reduce(OP_XOR, 7);
		write_reg(ADDR_CMD, command_word(OP_XOR, 7));
		wait_done();
		check_read("xor_result", ADDR_RESULT, expected);

		// Engine stalls on an empty FIFO
		push_words(3);
		write_reg(ADDR_CMD, command_word(OP_SUM, 6));
		check_read("short_sum_busy", ADDR_STATUS, status_word(1, 0, 0));
		push_words(3);
		expected = model_reduce(OP_SUM, 6);
		wait_done();
		check_read("short_sum_result", ADDR_RESULT, expected);

		// Second command arrives while the first one still pops
		push_words(6);
		write_reg(ADDR_CMD, command_word(OP_SUM, 6));
		write_reg(ADDR_CMD, command_word(OP_CLEAR, 0));
		assert (latency > 3)
		else fail_run("Command write during busy was acknowledged without being held");
		model_q.delete();
		wait_done();
		check_read("held_clear_result", ADDR_RESULT, 64'd0);

		push_words(16);
		check_read("full_status", ADDR_STATUS, status_word(0, 1, 16));
		write_reg(ADDR_CMD, command_word(OP_SUM, 1));
		expected = model_reduce(OP_SUM, 1);
		push_words(1); // Needs the slot freed by the pop
		check_read("refill_status", ADDR_STATUS, status_word(0, 1, 16));
		check_read("single_pop_result", ADDR_RESULT, expected);
		write_reg(ADDR_CMD, command_word(OP_CLEAR, 0));
		model_q.delete();
		check_read("flush_status", ADDR_STATUS, status_word(0, 1, 0));

		if (dut.protocol_checks.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "Protocol assertions reported errors");
		end
	end

endmodule

//--- wb_host_top.f
logic/wb_host_pkg.sv
logic/host_link_if.sv
logic/engine_ctrl_if.sv
logic/wb_slave.sv
logic/host_regs.sv
logic/data_fifo.sv
logic/cmd_engine.sv
logic/wb_host_top.sv
test/wb_host_asserts.sv
test/wb_host_tb.sv
